/* Bender.yml */
package:
  name: tex_unit

sources:
  - include_dirs:
      - .
    files:
      - tex_pkg.sv
      - tex_dcache_if.sv
      - tex_req_fifo.sv
      - tex_memory.sv
      - tex_texel_ram.sv
      - tex_unit_top.sv

  - target: test
    include_dirs:
      - .
    files:
      - tb_tex_unit.sv

/* compile.f */
+incdir+.
tex_pkg.sv
tex_dcache_if.sv
tex_req_fifo.sv
tex_memory.sv
tex_texel_ram.sv
tex_unit_top.sv
tb_tex_unit.sv

/* tb_tex_unit.sv */
`include "tex_config.svh"

module tb_tex_unit;
    import tex_pkg::*;

    localparam int NT       = `TEX_NUM_THREADS;
    localparam int AW       = `TEX_RAM_ADDR_BITS;
    localparam int HDR_W    = `TEX_NW_BITS + NT + 1 + `TEX_INFO_BITS;
    localparam int MAX_REQ  = 64;
    localparam int NUM_REQS = 48;
    localparam int WATCHDOG_CYCLES = NUM_REQS * 40 + 400;

    typedef logic [NT-1:0][3:0][31:0] texel_set_t;

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      req_valid;
    logic [`TEX_NW_BITS-1:0]   req_wid;
    logic [NT-1:0]             req_tmask;
    tex_filter_t               req_filter;
    tex_stride_t               req_stride;
    texel_set_t                req_addr;
    logic [`TEX_INFO_BITS-1:0] req_info;
    logic                      req_ready;
    logic                      rsp_valid;
    logic [`TEX_NW_BITS-1:0]   rsp_wid;
    logic [NT-1:0]             rsp_tmask;
    tex_filter_t               rsp_filter;
    texel_set_t                rsp_data;
    logic [`TEX_INFO_BITS-1:0] rsp_info;
    logic                      rsp_ready;
    logic                      mem_we;
    logic [AW-1:0]             mem_waddr;
    logic [31:0]               mem_wdata;

    logic [31:0]      lfsr_state = 32'h6d6ee913;
    logic [31:0]      mem_model [2**AW];
    texel_set_t       exp_data_mem [MAX_REQ];
    logic [HDR_W-1:0] exp_hdr_mem [MAX_REQ];
    texel_set_t       exp_data;
    logic [HDR_W-1:0] exp_hdr;
    int               req_cnt = 0;
    int               rsp_cnt = 0;
    int               err_count = 0;
    int               err_start;
    int               rsp_start;
    int               tests_run = 0;
    int               tests_failed = 0;
    logic             stall_mode = 1'b0;
    string            test_name = "reset";

    tex_unit_top UUT (.*);

    always #20 clk = ~clk;

    // taps 32, 22, 2, 1
    function logic next_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], next_bit()};
        end
        return r;
    endfunction

    function logic [NT-1:0] rand_mask();
        logic [NT-1:0] m;
        m = NT'(rand_bits(NT));
        return (m == '0) ? NT'(1) : m;
    endfunction

    function texel_set_t rand_addrs();
        texel_set_t a;
        for (int i = 0; i < NT; i++) begin
            for (int j = 0; j < 4; j++) begin
                a[i][j] = rand_bits(32);
            end
        end
        return a;
    endfunction

    // every lane hits one word per slot, upper bits and offsets still vary
    function texel_set_t same_word_addrs();
        texel_set_t    a;
        logic [AW-1:0] base;
        a = rand_addrs();
        for (int j = 0; j < 4; j++) begin
            base = AW'(rand_bits(AW));
            for (int i = 0; i < NT; i++) begin
                a[i][j][2 +: AW] = base;
            end
        end
        return a;
    endfunction

    function texel_set_t predict(input texel_set_t a, input logic [NT-1:0] m,
                                 input tex_filter_t f, input tex_stride_t s);
        texel_set_t d;
        tex_word_u  w;
        logic [1:0] o;
        d = '0;
        for (int i = 0; i < NT; i++) begin
            for (int j = 0; j < 4; j++) begin
                if (m[i] && (j == 0 || f == TEX_FILTER_BILINEAR)) begin
                    w = mem_model[a[i][j][2 +: AW]];
                    o = a[i][j][1:0];
                    if (s == TEX_STRIDE_BYTE) begin
                        d[i][j] = {24'd0, w.b[o]};
                    end else if (s == TEX_STRIDE_HALF) begin
                        d[i][j] = {16'd0, w.h[o[1]]};
                    end else begin
                        d[i][j] = w;
                    end
                end
            end
        end
        return d;
    endfunction

    // request and response bookkeeping
    always @(posedge clk) begin
        if (!reset && req_valid && req_ready) begin
            exp_data_mem[req_cnt] <= predict(req_addr, req_tmask, req_filter, req_stride);
            exp_hdr_mem[req_cnt]  <= {req_wid, req_tmask, req_filter, req_info};
            req_cnt <= req_cnt + 1;
        end
        if (!reset && rsp_valid && rsp_ready) begin
            rsp_cnt <= rsp_cnt + 1;
        end
    end

    assign exp_data = exp_data_mem[rsp_cnt];
    assign exp_hdr  = exp_hdr_mem[rsp_cnt];

    assert property (@(posedge clk) disable iff (reset)
        (rsp_valid && rsp_ready) |-> (rsp_cnt < req_cnt))
        else begin
            err_count++;
            $display("%s: response arrived with no request outstanding", test_name);
        end

    assert property (@(posedge clk) disable iff (reset)
        (rsp_valid && rsp_ready) |-> (rsp_data == exp_data))
        else begin
            err_count++;
            $display("Mismatch %s rsp_data: expected %h actual %h", test_name,
                     $sampled(exp_data), $sampled(rsp_data));
        end

    assert property (@(posedge clk) disable iff (reset)
        (rsp_valid && rsp_ready) |-> ({rsp_wid, rsp_tmask, rsp_filter, rsp_info} == exp_hdr))
        else begin
            err_count++;
            $display("Mismatch %s wid/tmask/filter/info: expected %h actual %h", test_name,
                     $sampled(exp_hdr), $sampled({rsp_wid, rsp_tmask, rsp_filter, rsp_info}));
        end

    assert property (@(posedge clk) disable iff (reset)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_data) && $stable(rsp_info)))
        else begin
            err_count++;
            $display("%s: held response dropped or changed before it was taken", test_name);
        end

    // inputs move 2 units after the edge
    task tick();
        @(posedge clk);
        #2;
        if (stall_mode) begin
            rsp_ready = next_bit();
        end
    endtask

    task drive_req(input tex_filter_t f, input tex_stride_t s, input logic [NT-1:0] m,
                   input texel_set_t a);
        req_valid  = 1'b1;
        req_wid    = `TEX_NW_BITS'(rand_bits(`TEX_NW_BITS));
        req_info   = `TEX_INFO_BITS'(rand_bits(`TEX_INFO_BITS));
        req_tmask  = m;
        req_filter = f;
        req_stride = s;
        req_addr   = a;
    endtask

    task send_req(input tex_filter_t f, input tex_stride_t s, input logic [NT-1:0] m,
                  input texel_set_t a);
        logic taken;
        drive_req(f, s, m, a);
        do begin
            taken = req_ready;
            tick();
        end while (!taken);
        req_valid = 1'b0;
    endtask

    task wait_idle();
        while (rsp_cnt != req_cnt) begin
            tick();
        end
    endtask

    task start_test(input string name);
        test_name = name;
        err_start = err_count;
        rsp_start = rsp_cnt;
    endtask

    task end_test();
        wait_idle();
        tests_run++;
        if (err_count != err_start) begin
            tests_failed++;
        end
        $display("test %-12s %0d responses checked, %0d errors", test_name,
                 rsp_cnt - rsp_start, err_count - err_start);
    endtask

    initial begin
        int accepted;
        int low_run;
        reset     = 1'b1;
        req_valid = 1'b0;
        req_wid   = '0;
        req_tmask = '0;
        req_filter = TEX_FILTER_POINT;
        req_stride = TEX_STRIDE_BYTE;
        req_addr  = '0;
        req_info  = '0;
        rsp_ready = 1'b1;
        mem_we    = 1'b0;
        mem_waddr = '0;
        mem_wdata = '0;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        assert (req_ready && !rsp_valid)
            else begin
                err_count++;
                $display("reset: req_ready low or rsp_valid high after reset");
            end

        for (int a = 0; a < 2**AW; a++) begin
            mem_we    = 1'b1;
            mem_waddr = AW'(a);
            mem_wdata = rand_bits(32);
            mem_model[a] = mem_wdata;
            tick();
        end
        mem_we = 1'b0;

        start_test("point_word");
        for (int k = 0; k < 6; k++) begin
            send_req(TEX_FILTER_POINT, 2'd2, rand_mask(), rand_addrs());
        end
        end_test();

        start_test("bilinear");
        for (int k = 0; k < 6; k++) begin
            send_req(TEX_FILTER_BILINEAR, 2'd3, rand_mask(), rand_addrs());
        end
        end_test();

        start_test("byte_half");
        for (int k = 0; k < 8; k++) begin
            send_req(tex_filter_t'(k[0]), tex_stride_t'(k[1]), rand_mask(), rand_addrs());
        end
        end_test();

        start_test("duplicate");
        send_req(TEX_FILTER_BILINEAR, 2'd2, 4'b1111, same_word_addrs());
        send_req(TEX_FILTER_BILINEAR, TEX_STRIDE_BYTE, 4'b1011, same_word_addrs());
        send_req(TEX_FILTER_POINT, TEX_STRIDE_HALF, 4'b1111, same_word_addrs());
        send_req(TEX_FILTER_BILINEAR, TEX_STRIDE_HALF, rand_mask(), same_word_addrs());
        end_test();

        start_test("thread_mask");
        send_req(TEX_FILTER_BILINEAR, 2'd2, 4'b1110, rand_addrs());
        send_req(TEX_FILTER_BILINEAR, TEX_STRIDE_BYTE, 4'b0100, rand_addrs());
        send_req(TEX_FILTER_POINT, 2'd2, 4'b1010, rand_addrs());
        // lane 0 off, so the shared words do not count as a duplicate
        send_req(TEX_FILTER_BILINEAR, 2'd2, 4'b0110, same_word_addrs());
        end_test();

        start_test("backpressure");
        stall_mode = 1'b1;
        for (int k = 0; k < 10; k++) begin
            send_req(tex_filter_t'(next_bit()), tex_stride_t'(rand_bits(2)), rand_mask(),
                     rand_addrs());
        end
        wait_idle();
        stall_mode = 1'b0;
        rsp_ready  = 1'b0;
        accepted   = 0;
        low_run    = 0;
        drive_req(TEX_FILTER_POINT, 2'd2, rand_mask(), rand_addrs());
        while (low_run < 8) begin
            if (req_ready) begin
                accepted++;
                low_run = 0;
                tick();
                drive_req(TEX_FILTER_POINT, 2'd2, rand_mask(), rand_addrs());
            end else begin
                low_run++;
                tick();
            end
        end
        req_valid = 1'b0;
        assert (accepted == `TEX_REQQ_SIZE + 1)
            else begin
                err_count++;
                $display("Mismatch %s accepted requests: expected %0d actual %0d", test_name,
                         `TEX_REQQ_SIZE + 1, accepted);
            end
        rsp_ready = 1'b1;
        end_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired in test %s before all responses returned", test_name);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* tex_config.svh */
`ifndef TEX_CONFIG_SVH
`define TEX_CONFIG_SVH

// lanes per warp
`define TEX_NUM_THREADS 4

// warp id width
`define TEX_NW_BITS 3

// pending request slots, power of two
`define TEX_REQQ_SIZE 4

// opaque request info carried through to the response
`define TEX_INFO_BITS 8

// word address width of each texel RAM lane
`define TEX_RAM_ADDR_BITS 8

`endif

/* tex_dcache_if.sv */
`include "tex_config.svh"

// per-lane fetch requests toward the texel RAM
interface tex_dcache_req_if;
    logic [`TEX_NUM_THREADS-1:0]                         valid;
    logic [`TEX_NUM_THREADS-1:0]                         ready;
    logic [`TEX_NUM_THREADS-1:0][`TEX_RAM_ADDR_BITS-1:0] addr;
    // quad slot index, same for every lane
    logic [1:0]                                          tag;

    modport master (
        output valid,
        output addr,
        output tag,
        input  ready
    );

    modport slave (
        input  valid,
        input  addr,
        input  tag,
        output ready
    );
endinterface

// fetched words coming back, one ready for all lanes
interface tex_dcache_rsp_if;
    logic [`TEX_NUM_THREADS-1:0]       valid;
    logic [`TEX_NUM_THREADS-1:0][31:0] data;
    logic [1:0]                        tag;
    logic                              ready;

    modport master (
        output valid,
        output data,
        output tag,
        input  ready
    );

    modport slave (
        input  valid,
        input  data,
        input  tag,
        output ready
    );
endinterface

/* tex_memory.sv */
`include "tex_config.svh"

module tex_memory (
    input  logic                                   clk,
    input  logic                                   reset,

    input  logic                                   req_valid,
    input  logic [`TEX_NW_BITS-1:0]                req_wid,
    input  logic [`TEX_NUM_THREADS-1:0]            req_tmask,
    input  tex_pkg::tex_filter_t                   req_filter,
    input  tex_pkg::tex_stride_t                   req_stride,
    input  logic [`TEX_NUM_THREADS-1:0][3:0][31:0] req_addr,
    input  logic [`TEX_INFO_BITS-1:0]              req_info,
    output logic                                   req_ready,

    output logic                                   rsp_valid,
    output logic [`TEX_NW_BITS-1:0]                rsp_wid,
    output logic [`TEX_NUM_THREADS-1:0]            rsp_tmask,
    output tex_pkg::tex_filter_t                   rsp_filter,
    output logic [`TEX_NUM_THREADS-1:0][3:0][31:0] rsp_data,
    output logic [`TEX_INFO_BITS-1:0]              rsp_info,
    input  logic                                   rsp_ready,

    tex_dcache_req_if.master                       dcache_req,
    tex_dcache_rsp_if.slave                        dcache_rsp
);
    import tex_pkg::*;

    localparam int NT    = `TEX_NUM_THREADS;
    localparam int AW    = `TEX_RAM_ADDR_BITS;
    localparam int CTR_W = $clog2(NT * 4 + 1);
    localparam int CNT_W = $clog2(NT + 1);

    tex_quad_req_t in_rec;
    tex_quad_req_t q;
    logic          q_push;
    logic          q_pop;
    logic          q_empty;
    logic          q_full;

    // split byte addresses into word and offset, one slot per texel
    always_comb begin : build_rec
        logic [NT-1:0] same_word;
        in_rec.wid    = req_wid;
        in_rec.tmask  = req_tmask;
        in_rec.filter = req_filter;
        in_rec.stride = req_stride;
        in_rec.info   = req_info;
        for (int j = 0; j < 4; j++) begin
            for (int i = 0; i < NT; i++) begin
                in_rec.addr[j][i]  = req_addr[i][j][2 +: AW];
                in_rec.align[j][i] = req_addr[i][j][1:0];
                same_word[i] = (req_addr[i][j][2 +: AW] == req_addr[0][j][2 +: AW])
                            || !req_tmask[i];
            end
            in_rec.dup[j] = req_tmask[0] && (&same_word);
        end
    end

    assign q_push    = req_valid && req_ready;
    assign req_ready = !q_full;

    tex_req_fifo req_queue (
        .clk      (clk),
        .reset    (reset),
        .push     (q_push),
        .pop      (q_pop),
        .data_in  (in_rec),
        .data_out (q),
        .empty    (q_empty),
        .full     (q_full)
    );

    logic [1:0]    slot_idx;
    logic [NT-1:0] sent_mask;
    logic          slots_done;
    logic          issue_valid;
    logic          slot_dup;
    logic          slot_sent;
    logic          last_sent;
    logic [NT-1:0] need_mask;
    logic [NT-1:0] req_fire;

    assign issue_valid = !q_empty && !slots_done;
    assign slot_dup    = q.dup[slot_idx];
    // duplicate slot goes out on lane 0 only
    assign need_mask   = q.tmask & {{(NT-1){!slot_dup}}, 1'b1};

    assign dcache_req.valid = {NT{issue_valid}} & need_mask & ~sent_mask;
    assign dcache_req.addr  = q.addr[slot_idx];
    assign dcache_req.tag   = slot_idx;

    assign req_fire  = dcache_req.valid & dcache_req.ready;
    assign slot_sent = issue_valid && (&(dcache_req.ready | sent_mask | ~need_mask));
    assign last_sent = slot_sent
                    && (slot_idx == ((q.filter == TEX_FILTER_BILINEAR) ? 2'd3 : 2'd0));

    always_ff @(posedge clk) begin
        if (reset || slot_sent) begin
            sent_mask <= '0;
        end else begin
            sent_mask <= sent_mask | req_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || last_sent) begin
            slot_idx <= 2'd0;
        end else if (slot_sent) begin
            slot_idx <= slot_idx + 2'd1;
        end
    end

    // head fully issued, wait for its texels
    always_ff @(posedge clk) begin
        if (reset || q_pop) begin
            slots_done <= 1'b0;
        end else if (last_sent) begin
            slots_done <= 1'b1;
        end
    end

    logic [1:0]               rsp_idx;
    logic                     rsp_dup;
    logic                     rsp_fire;
    logic                     texels_done;
    logic                     stall_out;
    logic [NT-1:0]            cur_mask;
    logic [CNT_W-1:0]         cur_cnt;
    logic [CTR_W-1:0]         max_cnt;
    logic [CTR_W-1:0]         rem_ctr;
    logic [NT-1:0][31:0]      lane_texel;
    logic [3:0][NT-1:0][31:0] texels;
    logic [3:0][NT-1:0][31:0] texels_n;
    logic [NT-1:0][3:0][31:0] texels_out;

    assign rsp_idx  = dcache_rsp.tag;
    assign rsp_dup  = q.dup[rsp_idx];
    assign rsp_fire = (|dcache_rsp.valid) && dcache_rsp.ready;
    assign cur_mask = rsp_dup ? q.tmask : dcache_rsp.valid;
    assign cur_cnt  = CNT_W'($countones(cur_mask));
    assign max_cnt  = CTR_W'($countones(q.tmask) * ((q.filter == TEX_FILTER_BILINEAR) ? 4 : 1));

    always_comb begin : extract
        tex_word_u  word;
        logic [1:0] offs;
        for (int i = 0; i < NT; i++) begin
            word = (rsp_dup ? dcache_rsp.data[0] : dcache_rsp.data[i]) & {32{cur_mask[i]}};
            offs = q.align[rsp_idx][i];
            case (q.stride)
                TEX_STRIDE_BYTE: lane_texel[i] = {24'd0, word.b[offs]};
                TEX_STRIDE_HALF: lane_texel[i] = {16'd0, word.h[offs[1]]};
                default:         lane_texel[i] = word;
            endcase
        end
    end

    always_comb begin
        texels_n          = texels;
        texels_n[rsp_idx] = texels[rsp_idx] | lane_texel;
        for (int i = 0; i < NT; i++) begin
            for (int j = 0; j < 4; j++) begin
                texels_out[i][j] = texels_n[j][i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || q_pop) begin
            texels <= '0;
        end else if (rsp_fire) begin
            texels <= texels_n;
        end
    end

    // texels still outstanding for the head request
    always_ff @(posedge clk) begin
        if (reset) begin
            rem_ctr <= '0;
        end else if ((|req_fire) && (rem_ctr == '0)) begin
            rem_ctr <= max_cnt;
        end else if (rsp_fire) begin
            rem_ctr <= rem_ctr - CTR_W'(cur_cnt);
        end
    end

    assign stall_out   = rsp_valid && !rsp_ready;
    assign texels_done = rsp_fire && (rem_ctr == CTR_W'(cur_cnt));
    assign q_pop       = texels_done && !stall_out;

    // only the final texel waits on a held output
    assign dcache_rsp.ready = !stall_out || (rem_ctr != CTR_W'(cur_cnt));

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (!stall_out) begin
            rsp_valid <= texels_done;
        end
    end

    always_ff @(posedge clk) begin
        if (q_pop) begin
            rsp_wid    <= q.wid;
            rsp_tmask  <= q.tmask;
            rsp_filter <= q.filter;
            rsp_data   <= texels_out;
            rsp_info   <= q.info;
        end
    end

    // point requests never see a tag past slot 0
    assert property (@(posedge clk) disable iff (reset)
        rsp_fire |-> (q.filter == TEX_FILTER_BILINEAR) || (rsp_idx == 2'd0))
        else $error("tex_memory: response tag %0d out of range", rsp_idx);

    assert property (@(posedge clk) disable iff (reset)
        rsp_fire |-> (rem_ctr >= CTR_W'(cur_cnt)))
        else $error("tex_memory: texel counter underflow");

endmodule

/* tex_pkg.sv */
`include "tex_config.svh"

package tex_pkg;

    // texel size, 2 and 3 both mean a full word
    typedef logic [1:0] tex_stride_t;

    localparam tex_stride_t TEX_STRIDE_BYTE = 2'd0;
    localparam tex_stride_t TEX_STRIDE_HALF = 2'd1;

    typedef enum logic {
        TEX_FILTER_POINT    = 1'b0,
        TEX_FILTER_BILINEAR = 1'b1
    } tex_filter_t;

    // one queued request, addresses already split per quad slot
    typedef struct packed {
        logic [3:0][`TEX_NUM_THREADS-1:0][`TEX_RAM_ADDR_BITS-1:0] addr;
        logic [3:0][`TEX_NUM_THREADS-1:0][1:0]                     align;
        logic [3:0]                                                dup;
        logic [`TEX_NW_BITS-1:0]                                   wid;
        logic [`TEX_NUM_THREADS-1:0]                               tmask;
        tex_filter_t                                               filter;
        tex_stride_t                                               stride;
        logic [`TEX_INFO_BITS-1:0]                                 info;
    } tex_quad_req_t;

    // fetched word, picked apart by byte or by halfword
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } tex_word_u;

endpackage

/* tex_req_fifo.sv */
`include "tex_config.svh"

module tex_req_fifo (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   push,
    input  logic                   pop,
    input  tex_pkg::tex_quad_req_t data_in,
    output tex_pkg::tex_quad_req_t data_out,
    output logic                   empty,
    output logic                   full
);
    import tex_pkg::*;

    localparam int DEPTH = `TEX_REQQ_SIZE;
    localparam int PTR_W = $clog2(DEPTH);

    tex_quad_req_t    entries [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= data_in;
        end
    end

    // pointers wrap naturally since depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head entry visible without a read cycle
    assign data_out = entries[rd_ptr];
    assign empty    = (count == '0);
    assign full     = (count == (PTR_W + 1)'(DEPTH));

    assert property (@(posedge clk) disable iff (reset) !(push && full))
        else $error("tex_req_fifo: push while full");

    assert property (@(posedge clk) disable iff (reset) !(pop && empty))
        else $error("tex_req_fifo: pop while empty");

endmodule

/* tex_texel_ram.sv */
`include "tex_config.svh"

module tex_texel_ram (
    input  logic                          clk,
    input  logic                          reset,
    tex_dcache_req_if.slave               req,
    tex_dcache_rsp_if.master              rsp,
    input  logic                          mem_we,
    input  logic [`TEX_RAM_ADDR_BITS-1:0] mem_waddr,
    input  logic [31:0]                   mem_wdata
);
    localparam int NT    = `TEX_NUM_THREADS;
    localparam int DEPTH = 2 ** `TEX_RAM_ADDR_BITS;

    logic [31:0]         words [NT][DEPTH];
    logic [NT-1:0]       fire;
    logic                stall;
    logic [NT-1:0]       valid_q;
    logic [NT-1:0][31:0] data_q;
    logic [1:0]          tag_q;

    // a response waiting on ready blocks every lane
    assign stall     = (|valid_q) && !rsp.ready;
    assign req.ready = {NT{!stall}};
    assign fire      = req.valid & req.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (!stall) begin
            valid_q <= fire;
        end
    end

    // load port writes the same word into every lane copy
    always_ff @(posedge clk) begin
        for (int i = 0; i < NT; i++) begin
            if (mem_we) begin
                words[i][mem_waddr] <= mem_wdata;
            end
            if (fire[i]) begin
                data_q[i] <= words[i][req.addr[i]];
            end
        end
        if (|fire) begin
            tag_q <= req.tag;
        end
    end

    assign rsp.valid = valid_q;
    assign rsp.data  = data_q;
    assign rsp.tag   = tag_q;

    // loading only happens while no fetch is in progress
    assert property (@(posedge clk) disable iff (reset) !(mem_we && (|fire)))
        else $error("tex_texel_ram: load write during fetch");

endmodule

/* tex_unit_top.sv */
`include "tex_config.svh"

module tex_unit_top (
    input  logic                                   clk,
    input  logic                                   reset,

    input  logic                                   req_valid,
    input  logic [`TEX_NW_BITS-1:0]                req_wid,
    input  logic [`TEX_NUM_THREADS-1:0]            req_tmask,
    input  tex_pkg::tex_filter_t                   req_filter,
    input  tex_pkg::tex_stride_t                   req_stride,
    input  logic [`TEX_NUM_THREADS-1:0][3:0][31:0] req_addr,
    input  logic [`TEX_INFO_BITS-1:0]              req_info,
    output logic                                   req_ready,

    output logic                                   rsp_valid,
    output logic [`TEX_NW_BITS-1:0]                rsp_wid,
    output logic [`TEX_NUM_THREADS-1:0]            rsp_tmask,
    output tex_pkg::tex_filter_t                   rsp_filter,
    output logic [`TEX_NUM_THREADS-1:0][3:0][31:0] rsp_data,
    output logic [`TEX_INFO_BITS-1:0]              rsp_info,
    input  logic                                   rsp_ready,

    input  logic                                   mem_we,
    input  logic [`TEX_RAM_ADDR_BITS-1:0]          mem_waddr,
    input  logic [31:0]                            mem_wdata
);
    tex_dcache_req_if dcache_req ();
    tex_dcache_rsp_if dcache_rsp ();

    tex_memory memory (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_wid    (req_wid),
        .req_tmask  (req_tmask),
        .req_filter (req_filter),
        .req_stride (req_stride),
        .req_addr   (req_addr),
        .req_info   (req_info),
        .req_ready  (req_ready),
        .rsp_valid  (rsp_valid),
        .rsp_wid    (rsp_wid),
        .rsp_tmask  (rsp_tmask),
        .rsp_filter (rsp_filter),
        .rsp_data   (rsp_data),
        .rsp_info   (rsp_info),
        .rsp_ready  (rsp_ready),
        .dcache_req (dcache_req),
        .dcache_rsp (dcache_rsp)
    );

    tex_texel_ram texel_ram (
        .clk       (clk),
        .reset     (reset),
        .req       (dcache_req),
        .rsp       (dcache_rsp),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata)
    );

endmodule
